//--- rtl/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// byte address width seen by both requesters
`define ADDR_WIDTH 32

// log2 of the RAM depth in bytes
`define RAM_ADDR_BITS 12

// bytes per word
`define WORD_BYTES 4

`define BYTE_WIDTH 8

`endif

//--- rtl/memPkg.sv
`default_nettype none

package memPkg;

    // who holds the RAM port
    typedef enum logic [1:0] {
        ownIdle  = 2'd0,
        ownData  = 2'd1,
        ownFetch = 2'd2
    } memOwner_e;

    typedef enum logic {
        opLoad  = 1'b0,
        opStore = 1'b1
    } memOp_e;

    // how a short load fills the upper bits
    typedef enum logic {
        extZero = 1'b0,
        extSign = 1'b1
    } extKind_e;

    // byte count, legal values 1, 2 and 4
    typedef logic [2:0] accLen_t;

endpackage

`default_nettype wire

//--- rtl/lsuDecode.sv
`timescale 1ns/100ps
`default_nettype none

module lsuDecode
    import memPkg::*;
(
    input  logic [2:0] funct3,
    input  memOp_e     store,
    output accLen_t    len,
    output extKind_e   ext,
    output logic       illegal
);

    always_comb begin
        len     = 3'd4;
        ext     = extZero;
        illegal = 1'b0;
        case (funct3)
            // lb / sb
            3'b000: begin
                len = 3'd1;
                ext = extSign;
            end
            // lh / sh
            3'b001: begin
                len = 3'd2;
                ext = extSign;
            end
            // lw / sw
            3'b010: begin
                len = 3'd4;
                ext = extSign;
            end
            // lbu, no unsigned store form
            3'b100: begin
                len     = 3'd1;
                ext     = extZero;
                illegal = (store == opStore);
            end
            // lhu
            3'b101: begin
                len     = 3'd2;
                ext     = extZero;
                illegal = (store == opStore);
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/loadExtend.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_params.svh"

module loadExtend
    import memPkg::*;
(
    input  logic [`WORD_BYTES*`BYTE_WIDTH-1:0] word,
    input  accLen_t                            len,
    input  extKind_e                           ext,
    output logic [`WORD_BYTES*`BYTE_WIDTH-1:0] value
);

    localparam int byteBits = `BYTE_WIDTH;
    localparam int wordBits = `WORD_BYTES * `BYTE_WIDTH;
    localparam int halfBits = 2 * byteBits;

    logic fillBit;

    always_comb begin
        fillBit = 1'b0;
        case (len)
            3'd1: begin
                fillBit = (ext == extSign) ? word[byteBits-1] : 1'b0;
                value   = {{(wordBits-byteBits){fillBit}}, word[byteBits-1:0]};
            end
            3'd2: begin
                fillBit = (ext == extSign) ? word[halfBits-1] : 1'b0;
                value   = {{(wordBits-halfBits){fillBit}}, word[halfBits-1:0]};
            end
            // full words pass straight through
            default: value = word;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/byteRam.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_params.svh"

module byteRam (
    input  logic                   clk,
    input  logic [`ADDR_WIDTH-1:0] addr,
    input  logic                   we,
    input  logic [`BYTE_WIDTH-1:0] wdata,
    output logic [`BYTE_WIDTH-1:0] rdata
);

    localparam int depth = 1 << `RAM_ADDR_BITS;

    logic [`BYTE_WIDTH-1:0]    mem [depth];
    logic [`RAM_ADDR_BITS-1:0] index;

    // upper address bits alias onto the same bytes
    assign index = addr[`RAM_ADDR_BITS-1:0];

    // power-up contents cleared
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    // read returns the old byte on a same-cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[index];
    end

endmodule

`default_nettype wire

//--- rtl/memCtrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_params.svh"

module memCtrl
    import memPkg::*;
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               rdy,
    input  logic                               ioFull,

    input  logic                               fetchEn,
    input  logic [`ADDR_WIDTH-1:0]             fetchAddr,

    input  logic                               dataReq,
    input  memOp_e                             dataOp,
    input  accLen_t                            dataLen,
    input  logic [`ADDR_WIDTH-1:0]             dataAddr,
    input  logic [`WORD_BYTES*`BYTE_WIDTH-1:0] dataWdata,

    input  logic [`BYTE_WIDTH-1:0]             ramRdata,
    output logic [`ADDR_WIDTH-1:0]             ramAddr,
    output logic                               ramWe,
    output logic [`BYTE_WIDTH-1:0]             ramWdata,

    output logic                               fetchDone,
    output logic [`WORD_BYTES*`BYTE_WIDTH-1:0] fetchInst,
    output logic                               dataDone,
    output logic [`WORD_BYTES*`BYTE_WIDTH-1:0] dataWord,
    output memOwner_e                          owner
);

    localparam int      addrBits = `ADDR_WIDTH;
    localparam int      byteBits = `BYTE_WIDTH;
    localparam int      wordBits = `WORD_BYTES * `BYTE_WIDTH;
    localparam accLen_t fetchLen = accLen_t'(`WORD_BYTES);

    logic [2:0]                      stage;
    memOwner_e                       ownerQ;
    memOwner_e                       curOwner;
    logic [wordBits-byteBits-1:0]    wordBytes;
    logic                            active;
    logic                            lastHit;
    logic [2:0]                      readIdx;
    logic [addrBits-1:0]             baseAddr;

    assign active = rdy && !ioFull;

    // a running access keeps the bus, otherwise data beats fetch
    always_comb begin
        if (ownerQ != ownIdle) begin
            curOwner = ownerQ;
        end else if (dataReq) begin
            curOwner = ownData;
        end else if (fetchEn) begin
            curOwner = ownFetch;
        end else begin
            curOwner = ownIdle;
        end
    end

    assign owner = curOwner;

    // completing stage for the current owner
    always_comb begin
        case (curOwner)
            ownData: begin
                if (dataOp == opStore) begin
                    lastHit = (stage == dataLen - 3'd1);
                end else begin
                    lastHit = (stage == dataLen);
                end
            end
            ownFetch: lastHit = (stage == fetchLen);
            default:  lastHit = 1'b0;
        endcase
    end

    assign fetchDone = active && lastHit && (curOwner == ownFetch);
    assign dataDone  = active && lastHit && (curOwner == ownData);

    // while stalled, re-read the previous byte so ramRdata still holds it
    assign readIdx  = (!active && stage != 3'd0) ? stage - 3'd1 : stage;
    assign baseAddr = (curOwner == ownFetch) ? fetchAddr : dataAddr;
    assign ramAddr  = baseAddr + addrBits'(readIdx);

    assign ramWe    = active && (curOwner == ownData) && (dataOp == opStore);
    assign ramWdata = dataWdata[stage[1:0]*byteBits +: byteBits];

    always_ff @(posedge clk) begin
        if (rst) begin
            stage  <= 3'd0;
            ownerQ <= ownIdle;
        end else if (active) begin
            if (lastHit) begin
                stage  <= 3'd0;
                ownerQ <= ownIdle;
            end else if (curOwner != ownIdle) begin
                stage  <= stage + 3'd1;
                ownerQ <= curOwner;
            end
        end
    end

    // byte k-1 arrives at stage k
    always_ff @(posedge clk) begin
        if (active) begin
            case (stage)
                3'd1:    wordBytes[byteBits-1:0]            <= ramRdata;
                3'd2:    wordBytes[2*byteBits-1:byteBits]   <= ramRdata;
                3'd3:    wordBytes[3*byteBits-1:2*byteBits] <= ramRdata;
                default: ;
            endcase
        end
    end

    // little-endian, last byte straight from the RAM
    assign fetchInst = {ramRdata, wordBytes};

    always_comb begin
        case (dataLen)
            3'd1:    dataWord = {{(wordBits-byteBits){1'b0}}, ramRdata};
            3'd2:    dataWord = {{(wordBits-2*byteBits){1'b0}}, ramRdata,
                                 wordBytes[byteBits-1:0]};
            default: dataWord = {ramRdata, wordBytes};
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/memSubsystem.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_params.svh"

module memSubsystem
    import memPkg::*;
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               rdy,
    input  logic                               ioFull,

    input  logic                               fetchEn,
    input  logic [`ADDR_WIDTH-1:0]             fetchAddr,
    output logic                               fetchDone,
    output logic [`WORD_BYTES*`BYTE_WIDTH-1:0] fetchInst,

    input  logic                               dataEn,
    input  logic                               dataStore,
    input  logic [2:0]                         dataFunct3,
    input  logic [`ADDR_WIDTH-1:0]             dataAddr,
    input  logic [`WORD_BYTES*`BYTE_WIDTH-1:0] dataWdata,
    output logic                               dataDone,
    output logic [`WORD_BYTES*`BYTE_WIDTH-1:0] dataRdata,
    output logic                               dataError,

    output memOwner_e                          owner
);

    accLen_t                            dataLen;
    extKind_e                           dataExt;
    logic                               dataIllegal;
    logic                               dataReq;
    logic [`WORD_BYTES*`BYTE_WIDTH-1:0] dataWord;
    logic [`ADDR_WIDTH-1:0]             ramAddr;
    logic                               ramWe;
    logic [`BYTE_WIDTH-1:0]             ramWdata;
    logic [`BYTE_WIDTH-1:0]             ramRdata;

    lsuDecode lsuDecode_inst (
        .funct3  (dataFunct3),
        .store   (dataStore ? opStore : opLoad),
        .len     (dataLen),
        .ext     (dataExt),
        .illegal (dataIllegal)
    );

    // illegal codes never reach the controller
    assign dataReq   = dataEn && !dataIllegal;
    assign dataError = dataEn && dataIllegal;

    memCtrl memCtrl_inst (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .ioFull    (ioFull),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .dataReq   (dataReq),
        .dataOp    (dataStore ? opStore : opLoad),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .ramRdata  (ramRdata),
        .ramAddr   (ramAddr),
        .ramWe     (ramWe),
        .ramWdata  (ramWdata),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataDone  (dataDone),
        .dataWord  (dataWord),
        .owner     (owner)
    );

    loadExtend loadExtend_inst (
        .word  (dataWord),
        .len   (dataLen),
        .ext   (dataExt),
        .value (dataRdata)
    );

    byteRam byteRam_inst (
        .clk   (clk),
        .addr  (ramAddr),
        .we    (ramWe),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

`default_nettype wire

//--- dv/memSubsystem_properties.sv
`timescale 1ns/100ps
`default_nettype none

module memSubsystemProperties
    import memPkg::*;
(
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       rdy,
    input wire logic       ioFull,
    input wire logic       dataStore,
    input wire logic [2:0] dataFunct3,
    input wire logic       fetchDone,
    input wire logic       dataDone,
    input wire memOwner_e  owner
);

    logic      active;
    memOwner_e prevOwner;
    logic      fetchStart;
    logic      dataStart;
    int        failCount = 0;

    assign active = rdy && !ioFull;

    // owner one cycle back
    always_ff @(posedge clk) begin
        if (rst) begin
            prevOwner <= ownIdle;
        end else begin
            prevOwner <= owner;
        end
    end

    assign fetchStart = (owner == ownFetch) && (prevOwner != ownFetch);
    assign dataStart  = (owner == ownData) && (prevOwner != ownData);

    doneFetchOnce: assert property (@(posedge clk) disable iff (rst)
        fetchDone |=> !fetchDone)
    else begin
        failCount++;
        $error("fetchDone longer than one cycle");
    end

    doneDataOnce: assert property (@(posedge clk) disable iff (rst)
        dataDone |=> !dataDone)
    else begin
        failCount++;
        $error("dataDone longer than one cycle");
    end

    doneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(fetchDone && dataDone))
    else begin
        failCount++;
        $error("fetchDone and dataDone together");
    end

    noDoneInStall: assert property (@(posedge clk) disable iff (rst)
        !active |-> !fetchDone && !dataDone)
    else begin
        failCount++;
        $error("done while stalled");
    end

    // unstalled latencies
    fetchLatency: assert property (@(posedge clk) disable iff (rst)
        fetchStart && active ##1 active [*4] |-> fetchDone)
    else begin
        failCount++;
        $error("fetch done not 4 cycles after start");
    end

    wordLoadLatency: assert property (@(posedge clk) disable iff (rst)
        dataStart && !dataStore && dataFunct3 == 3'b010 && active ##1 active [*4]
        |-> dataDone)
    else begin
        failCount++;
        $error("lw done not 4 cycles after start");
    end

    byteLoadLatency: assert property (@(posedge clk) disable iff (rst)
        dataStart && !dataStore && dataFunct3[1:0] == 2'b00 && active ##1 active
        |-> dataDone)
    else begin
        failCount++;
        $error("byte load done not 1 cycle after start");
    end

    wordStoreLatency: assert property (@(posedge clk) disable iff (rst)
        dataStart && dataStore && dataFunct3 == 3'b010 && active ##1 active [*3]
        |-> dataDone)
    else begin
        failCount++;
        $error("sw done not 3 cycles after start");
    end

endmodule

bind memSubsystem memSubsystemProperties props_inst (.*);

`default_nettype wire

//--- dv/memSubsystemTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_params.svh"

module memSubsystemTb
    import memPkg::*;
;

    logic        clk;
    logic        rst;
    logic        rdy;
    logic        ioFull;
    logic        fetchEn;
    logic [31:0] fetchAddr;
    logic        fetchDone;
    logic [31:0] fetchInst;
    logic        dataEn;
    logic        dataStore;
    logic [2:0]  dataFunct3;
    logic [31:0] dataAddr;
    logic [31:0] dataWdata;
    logic        dataDone;
    logic [31:0] dataRdata;
    logic        dataError;
    memOwner_e   owner;

    logic [7:0]  model [1 << `RAM_ADDR_BITS];
    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          cycleCount;

    memSubsystem memSubsystem_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= 4000) begin
            $display("timeout: run did not finish within 4000 cycles");
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int lenOf(input logic [2:0] f3);
        return (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
    endfunction

    // little-endian word from the model
    function automatic logic [31:0] modelWord(input logic [31:0] addr, input int n);
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < n; k++) begin
            w[8*k +: 8] = model[(addr + k) & ((1 << `RAM_ADDR_BITS) - 1)];
        end
        return w;
    endfunction

    function automatic logic [31:0] expectLoad(input logic [2:0] f3, input logic [31:0] addr);
        logic [31:0] raw;
        raw = modelWord(addr, lenOf(f3));
        case (lenOf(f3))
            1: return f3[2] ? raw : {{24{raw[7]}}, raw[7:0]};
            2: return f3[2] ? raw : {{16{raw[15]}}, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    task automatic expectTrue(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Fail %0t: %s", $time, msg);
        end
    endtask

    task automatic driveStall(input bit stalls);
        rdy    = stalls ? (randBits(3) != 0) : 1'b1;
        ioFull = stalls ? (randBits(3) == 0) : 1'b0;
    endtask

    task automatic dataAccess(input logic st, input logic [2:0] f3, input logic [31:0] addr,
                              input logic [31:0] wdata, input bit stalls);
        int  edges;
        int  stallCount;
        int  n;
        bit  finished;
        n          = lenOf(f3);
        edges      = 0;
        stallCount = 0;
        finished   = 0;
        @(negedge clk);
        dataEn     = 1'b1;
        dataStore  = st;
        dataFunct3 = f3;
        dataAddr   = addr;
        dataWdata  = wdata;
        driveStall(stalls);
        while (!finished) begin
            @(posedge clk);
            edges++;
            if (dataDone) begin
                finished = 1;
                if (!st) begin
                    expectTrue(dataRdata == expectLoad(f3, addr),
                        $sformatf("load f3=%0d addr=%h got %h exp %h", f3, addr,
                                  dataRdata, expectLoad(f3, addr)));
                end
            end else begin
                if (!(rdy && !ioFull)) stallCount++;
                @(negedge clk);
                driveStall(stalls);
            end
        end
        expectTrue(edges == (st ? n : n + 1) + stallCount,
            $sformatf("data latency %0d cycles with %0d stalls", edges - 1, stallCount));
        if (st) begin
            for (int k = 0; k < n; k++) begin
                model[(addr + k) & ((1 << `RAM_ADDR_BITS) - 1)] = wdata[8*k +: 8];
            end
        end
        @(negedge clk);
        dataEn = 1'b0;
        driveStall(0);
    endtask

    task automatic fetchAccess(input logic [31:0] addr, input bit stalls);
        int edges;
        int stallCount;
        bit finished;
        edges      = 0;
        stallCount = 0;
        finished   = 0;
        @(negedge clk);
        fetchEn   = 1'b1;
        fetchAddr = addr;
        driveStall(stalls);
        while (!finished) begin
            @(posedge clk);
            edges++;
            if (fetchDone) begin
                finished = 1;
                expectTrue(fetchInst == modelWord(addr, 4),
                    $sformatf("fetch addr=%h got %h exp %h", addr, fetchInst,
                              modelWord(addr, 4)));
            end else begin
                if (!(rdy && !ioFull)) stallCount++;
                @(negedge clk);
                driveStall(stalls);
            end
        end
        expectTrue(edges == 5 + stallCount,
            $sformatf("fetch latency %0d cycles with %0d stalls", edges - 1, stallCount));
        @(negedge clk);
        fetchEn = 1'b0;
        driveStall(0);
    endtask

    // data wins when both requesters ask at once
    task automatic priorityAccess(input logic [31:0] fAddr, input logic [31:0] dAddr);
        @(negedge clk);
        fetchEn    = 1'b1;
        fetchAddr  = fAddr;
        dataEn     = 1'b1;
        dataStore  = 1'b0;
        dataFunct3 = 3'b010;
        dataAddr   = dAddr;
        @(posedge clk);
        expectTrue(owner == ownData, "owner not ownData with both requests");
        while (!dataDone) begin
            expectTrue(!fetchDone, "fetchDone before dataDone");
            @(posedge clk);
        end
        expectTrue(dataRdata == modelWord(dAddr, 4), "load word wrong under priority");
        @(negedge clk);
        dataEn = 1'b0;
        @(posedge clk);
        while (!fetchDone) begin
            @(posedge clk);
        end
        expectTrue(fetchInst == modelWord(fAddr, 4), "fetch word wrong after priority");
        @(negedge clk);
        fetchEn = 1'b0;
    endtask

    task automatic illegalAccess(input logic st, input logic [2:0] f3, input logic [31:0] addr);
        @(negedge clk);
        dataEn     = 1'b1;
        dataStore  = st;
        dataFunct3 = f3;
        dataAddr   = addr;
        dataWdata  = randBits(32);
        repeat (3) begin
            @(posedge clk);
            expectTrue(dataError && !dataDone && owner == ownIdle,
                $sformatf("illegal f3=%0d store=%0b not rejected", f3, st));
        end
        @(negedge clk);
        dataEn = 1'b0;
        // memory must still match the model
        dataAccess(1'b0, 3'b010, addr, '0, 0);
    endtask

    initial begin
        logic [2:0]  loadCodes [5];
        logic [2:0]  f3;
        logic [31:0] addr;
        loadCodes  = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        lfsr       = 16'd10517;
        errors     = 0;
        checks     = 0;
        cycleCount = 0;
        rst        = 1'b1;
        rdy        = 1'b1;
        ioFull     = 1'b0;
        fetchEn    = 1'b0;
        fetchAddr  = '0;
        dataEn     = 1'b0;
        dataStore  = 1'b0;
        dataFunct3 = '0;
        dataAddr   = '0;
        dataWdata  = '0;
        for (int i = 0; i < (1 << `RAM_ADDR_BITS); i++) begin
            model[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        expectTrue(!fetchDone && !dataDone && !dataError && owner == ownIdle,
            "outputs not idle after reset");

        repeat (40) begin
            addr = randBits(6);
            dataAccess(1'b1, loadCodes[randBits(2) % 3], addr, randBits(32), 0);
            dataAccess(1'b0, loadCodes[randBits(3) % 5], addr, '0, 0);
        end
        repeat (20) fetchAccess(randBits(6), 0);
        repeat (10) priorityAccess(randBits(6), randBits(6));
        repeat (25) begin
            addr = randBits(6);
            dataAccess(1'b1, loadCodes[randBits(2) % 3], addr, randBits(32), 1);
            dataAccess(1'b0, loadCodes[randBits(3) % 5], addr, '0, 1);
            fetchAccess(addr, 1);
        end
        repeat (6) begin
            f3 = (randBits(1) == 0) ? 3'd3 : 3'd6 + 3'(randBits(1));
            illegalAccess(1'b0, f3, randBits(6));
            illegalAccess(1'b1, 3'd3 + 3'(randBits(3) % 5), randBits(6));
        end

        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 memSubsystem_inst.props_inst.failCount);
        if (errors == 0 && memSubsystem_inst.props_inst.failCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
rtl/memPkg.sv
rtl/lsuDecode.sv
rtl/loadExtend.sv
rtl/byteRam.sv
rtl/memCtrl.sv
rtl/memSubsystem.sv
dv/memSubsystem_properties.sv
dv/memSubsystemTb.sv

//--- run.sh
#!/bin/sh
# build and run the memSubsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module memSubsystemTb -Mdir obj_dir -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "TESTBENCH FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"
